// File: run_sim.sh
#!/bin/sh
# build the cache directory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=sim_cache_dir

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
   --top-module tb_cache_dir -f sim.f --Mdir "$OBJ" -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q -F '*** TEST PASSED ***' "$LOG"; then
   echo "simulation passed"
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: sim.f
src/cdir_pkg.sv
src/tag_store.sv
src/plru_tree.sv
src/dir_ctrl.sv
src/cache_dir.sv
sim/clk_gen.sv
sim/tb_cache_dir.sv

// File: sim/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
   output logic clk,
   output logic rst
);

   localparam time HALF_PERIOD = 10ns;    // 20 ns clock
   localparam int  RST_CYCLES  = 4;

   // free running clock
   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // reset high for the first RST_CYCLES rising edges
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;                         // drops together with the edge
   end

endmodule

`default_nettype wire

// File: sim/tb_cache_dir.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache_dir;

   import cdir_pkg::*;

   localparam int RESET_TIMEOUT = 20;     // cycles allowed for reset release
   localparam int DRAIN_TIMEOUT = 10;     // cycles allowed to empty the queue
   localparam int N_RANDOM      = 4000;   // random cycles

   logic     clk;
   logic     rst;
   logic     req_valid;
   dir_req_t req;
   logic     rsp_valid;
   dir_rsp_t rsp;

   // reference model, one entry per set
   logic [N_WAYS-1:0] m_valid [N_SETS];
   logic [TAG_W-1:0]  m_tag   [N_SETS][N_WAYS];
   logic [N_WAYS-1:1] m_tree  [N_SETS];   // heap numbered, node 1 is the root

   dir_rsp_t exp_q [$];                   // expected responses in issue order
   logic     cur_issue;                   // request driven at the latest edge
   logic     prev_issue;                  // request driven one edge before
   integer   seed;
   int       n_mismatch;
   int       n_other;
   int       n_checked;

   clk_gen i_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   cache_dir i_dut (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   // walk down from the root, 0 goes left and 1 goes right
   function automatic int tree_victim(input logic [N_WAYS-1:1] t);
      int node;
      node = 1;
      while (node < N_WAYS) begin
         node = 2 * node + int'(t[node]);
      end
      return node - N_WAYS;               // leaf id to way
   endfunction

   // every node on the path turns away from the accessed way
   function automatic logic [N_WAYS-1:1] tree_touch(input logic [N_WAYS-1:1] t,
                                                    input int way);
      logic [N_WAYS-1:1] nt;
      int                node;
      nt   = t;
      node = way + N_WAYS;
      while (node > 1) begin
         nt[node / 2] = (node % 2 == 0);  // came up from the left, point right
         node         = node / 2;
      end
      return nt;
   endfunction

   // expected response for one request, model state moves on with it
   task automatic model_access(input dir_req_t r, output dir_rsp_t e);
      int hit_w;
      int free_w;
      int w;
      e      = '0;
      hit_w  = -1;
      free_w = -1;
      for (int i = N_WAYS - 1; i >= 0; i--) begin
         if (m_valid[r.set][i] && m_tag[r.set][i] == r.tag) hit_w = i;
         if (!m_valid[r.set][i]) free_w = i;     // ends on the lowest invalid way
      end
      case (r.op)
         OP_LOOKUP: begin
            if (hit_w >= 0) w = hit_w;
            else if (free_w >= 0) w = free_w;
            else w = tree_victim(m_tree[r.set]);
            e.hit = (hit_w >= 0);
            e.way = WAY_W'(w);
            if (hit_w < 0 && free_w < 0) begin
               e.evict     = 1'b1;
               e.evict_tag = m_tag[r.set][w];   // line pushed out
            end
            m_valid[r.set][w] = 1'b1;           // same values again on a hit
            m_tag[r.set][w]   = r.tag;
            m_tree[r.set]     = tree_touch(m_tree[r.set], w);
         end
         OP_PROBE, OP_INVAL: begin
            if (hit_w >= 0) begin
               e.hit = 1'b1;
               e.way = WAY_W'(hit_w);
               if (r.op == OP_INVAL) m_valid[r.set][hit_w] = 1'b0;
            end
         end
         default: ;
      endcase
   endtask

   task automatic check_rsp(input dir_rsp_t got, input dir_rsp_t exp);
      n_checked++;
      if (got !== exp) begin
         n_mismatch++;
         $display("FAIL rsp got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp) begin
         n_mismatch++;
         $display("FAIL rsp_valid got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   // drive at the rising edge, look at the response at the falling edge
   task automatic run_cycle(input logic issue, input dir_req_t r);
      dir_rsp_t e;
      dir_rsp_t e_new;
      @(posedge clk);
      req_valid  <= issue;
      req        <= r;                    // payload driven even when idle
      prev_issue = cur_issue;
      cur_issue  = issue;
      if (issue) begin
         model_access(r, e_new);
      end
      @(negedge clk);
      check_valid(rsp_valid, prev_issue);   // answer to the previous edge's request
      if (rsp_valid) begin
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();          // oldest outstanding request
            check_rsp(rsp, e);
         end else begin
            $display("response seen with no request outstanding at %0t", $time);
            n_other++;
         end
      end
      if (issue) begin
         exp_q.push_back(e_new);            // due at the next falling edge
      end
   endtask

   task automatic send_req(input dir_op_e op, input logic [SET_W-1:0] set,
                           input logic [TAG_W-1:0] tag);
      dir_req_t r;
      r.op  = op;
      r.set = set;
      r.tag = tag;
      run_cycle(1'b1, r);
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, '0);
   endtask

   initial begin
      dir_req_t    r;
      logic [31:0] rnd;
      logic        issue;
      int          sel;
      int          cnt;
      seed       = 95114;
      req_valid  = 1'b0;
      req        = '0;
      cur_issue  = 1'b0;
      prev_issue = 1'b0;
      n_mismatch = 0;
      n_other    = 0;
      n_checked  = 0;
      r          = '0;
      for (int s = 0; s < N_SETS; s++) begin
         m_valid[s] = '0;
         m_tree[s]  = '0;                 // all nodes point left after reset
         for (int w = 0; w < N_WAYS; w++) begin
            m_tag[s][w] = '0;
         end
      end

      cnt = 0;
      while (rst !== 1'b0 && cnt < RESET_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (rst !== 1'b0) begin
         $display("reset was not released within %0d cycles", RESET_TIMEOUT);
         n_other++;
      end

      // quiet after reset, response bus stays zero
      for (int i = 0; i < 3; i++) begin
         idle_cycle();
         check_rsp(rsp, '0);
      end

      // empty set fills ways 0 to 3 in order
      for (int i = 0; i < N_WAYS; i++) begin
         send_req(OP_LOOKUP, 4'd5, TAG_W'(8'h10 + i));
      end
      idle_cycle();
      send_req(OP_LOOKUP, 4'd5, 8'h11);   // hits move the victim
      send_req(OP_LOOKUP, 4'd5, 8'h10);
      send_req(OP_LOOKUP, 4'd5, 8'h14);   // full set, tree victim goes
      send_req(OP_LOOKUP, 4'd5, 8'h14);   // resident now
      send_req(OP_PROBE,  4'd5, 8'h15);   // miss, nothing allocated
      send_req(OP_PROBE,  4'd5, 8'h15);
      send_req(OP_PROBE,  4'd5, 8'h11);   // hit, tree untouched
      send_req(OP_LOOKUP, 4'd5, 8'h16);   // same victim as before the probes
      send_req(OP_INVAL,  4'd5, 8'h14);
      send_req(OP_LOOKUP, 4'd5, 8'h14);   // back into the freed way
      send_req(OP_INVAL,  4'd5, 8'h77);   // absent tag
      idle_cycle();

      // random mix on a few sets with a handful of tags
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd   = $unsigned($random(seed));
         sel   = int'(rnd[11:8]) % 5;
         issue = (rnd[15:13] != 3'd0);    // about one gap in eight
         r.tag = TAG_W'(8'h40 + rnd[2:0]);
         if (!rnd[3]) r.set = SET_W'(rnd[5:4]);   // else same set again
         if (sel < 3) r.op = OP_LOOKUP;
         else if (sel == 3) r.op = OP_PROBE;
         else r.op = OP_INVAL;
         run_cycle(issue, r);
      end

      cnt = 0;
      while (exp_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
         idle_cycle();
         cnt++;
      end
      if (exp_q.size() != 0) begin
         $display("%0d responses still outstanding after the drain timeout", exp_q.size());
         n_other++;
      end
      idle_cycle();                       // rsp_valid must be low again
      if (n_checked == 0) begin
         $display("no response was ever checked");
         n_other++;
      end

      $display("errors: %0d value mismatches, %0d other, %0d responses checked",
               n_mismatch, n_other, n_checked);
      if (n_mismatch == 0 && n_other == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src/cache_dir.sv
`timescale 1ns/10ps
`default_nettype none

module cache_dir (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     req_valid,
   input  wire cdir_pkg::dir_req_t req,
   output logic                    rsp_valid,
   output cdir_pkg::dir_rsp_t      rsp
);

   import cdir_pkg::*;

   // tag store to controller
   logic [N_WAYS-1:0]            way_hit;
   logic [N_WAYS-1:0]            way_valid;
   logic [N_WAYS-1:0][TAG_W-1:0] way_tags;

   // tree to controller
   logic [WAY_W-1:0]             victim_way;

   // controller back to the stores
   tag_wr_t                      tag_wr;
   plru_upd_t                    plru_upd;

   tag_store i_tag_store (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req       (req),
      .tag_wr    (tag_wr),
      .way_hit   (way_hit),
      .way_valid (way_valid),
      .way_tags  (way_tags)
   );

   plru_tree i_plru_tree (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .plru_upd   (plru_upd),
      .victim_way (victim_way)
   );

   dir_ctrl i_dir_ctrl (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req        (req),
      .way_hit    (way_hit),
      .way_valid  (way_valid),
      .way_tags   (way_tags),
      .victim_way (victim_way),
      .tag_wr     (tag_wr),
      .plru_upd   (plru_upd),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

`default_nettype wire

// File: src/cdir_pkg.sv
`default_nettype none

package cdir_pkg;

   // directory geometry
   localparam int N_WAYS = 4;              // ways per set
   localparam int WAY_W  = 2;              // bits to name a way
   localparam int SET_W  = 4;              // set index width
   localparam int N_SETS = 1 << SET_W;     // 16 sets
   localparam int TAG_W  = 8;              // stored tag width

   // request operations
   typedef enum logic [1:0] {
      OP_LOOKUP = 2'd0,                    // look up, allocate on miss
      OP_PROBE  = 2'd1,                    // report only
      OP_INVAL  = 2'd2                     // drop the line if present
   } dir_op_e;

   // one request, 14 bits
   typedef struct packed {
      dir_op_e            op;
      logic [SET_W-1:0]   set;
      logic [TAG_W-1:0]   tag;
   } dir_req_t;

   // one response, 12 bits
   typedef struct packed {
      logic               hit;
      logic [WAY_W-1:0]   way;             // hit way or allocated way
      logic               evict;           // a valid line was replaced
      logic [TAG_W-1:0]   evict_tag;       // tag of the replaced line
   } dir_rsp_t;

   // tag store write, tag itself comes from the request
   typedef struct packed {
      logic               en;
      logic [WAY_W-1:0]   way;
      logic               valid;           // new valid bit
   } tag_wr_t;

   // tree update for an access to one way
   typedef struct packed {
      logic               en;
      logic [WAY_W-1:0]   way;             // way that was touched
   } plru_upd_t;

endpackage

`default_nettype wire

// File: src/dir_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dir_ctrl (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      req_valid,
   input  wire cdir_pkg::dir_req_t  req,
   input  wire [cdir_pkg::N_WAYS-1:0]                      way_hit,
   input  wire [cdir_pkg::N_WAYS-1:0]                      way_valid,
   input  wire [cdir_pkg::N_WAYS-1:0][cdir_pkg::TAG_W-1:0] way_tags,
   input  wire [cdir_pkg::WAY_W-1:0]                       victim_way,
   output cdir_pkg::tag_wr_t        tag_wr,
   output cdir_pkg::plru_upd_t      plru_upd,
   output logic                     rsp_valid,
   output cdir_pkg::dir_rsp_t       rsp
);

   import cdir_pkg::*;

   logic             any_hit;
   logic             any_free;   // at least one invalid way in the set
   logic [WAY_W-1:0] hit_way;
   logic [WAY_W-1:0] free_way;   // lowest invalid way
   logic [WAY_W-1:0] alloc_way;
   dir_rsp_t         rsp_nxt;

   assign any_hit  = |way_hit;
   assign any_free = ~&way_valid;

   // hit vector is one-hot or zero, so or-ing indices is enough
   always_comb begin
      hit_way = '0;
      for (int w = 0; w < N_WAYS; w++) begin
         if (way_hit[w]) hit_way = hit_way | WAY_W'(w);
      end
   end

   // priority encoder, scan from the top so the lowest index wins
   always_comb begin
      free_way = '0;
      for (int w = N_WAYS-1; w >= 0; w--) begin
         if (!way_valid[w]) free_way = WAY_W'(w);
      end
   end

   // fill an empty way first, otherwise take the tree victim
   assign alloc_way = any_free ? free_way : victim_way;

   // decision
   always_comb begin
      tag_wr   = '0;
      plru_upd = '0;
      rsp_nxt  = '0;
      if (req_valid) begin
         case (req.op)
            OP_LOOKUP: begin
               if (any_hit) begin
                  rsp_nxt.hit  = 1'b1;
                  rsp_nxt.way  = hit_way;
                  plru_upd.en  = 1'b1;      // touch only, tags unchanged
                  plru_upd.way = hit_way;
               end else begin
                  rsp_nxt.way  = alloc_way;
                  if (!any_free) begin
                     rsp_nxt.evict     = 1'b1;
                     rsp_nxt.evict_tag = way_tags[victim_way];  // old tag leaving
                  end
                  tag_wr.en    = 1'b1;      // install request tag
                  tag_wr.way   = alloc_way;
                  tag_wr.valid = 1'b1;
                  plru_upd.en  = 1'b1;
                  plru_upd.way = alloc_way;
               end
            end
            OP_PROBE: begin
               rsp_nxt.hit = any_hit;
               rsp_nxt.way = hit_way;       // zero on a miss
            end
            OP_INVAL: begin
               if (any_hit) begin
                  rsp_nxt.hit  = 1'b1;
                  rsp_nxt.way  = hit_way;
                  tag_wr.en    = 1'b1;      // clear valid, tree left alone
                  tag_wr.way   = hit_way;
                  tag_wr.valid = 1'b0;
               end
            end
            default: ;                      // unused encoding, no effect
         endcase
      end
   end

   // response comes out one cycle after the request
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
         rsp       <= '0;
      end else begin
         rsp_valid <= req_valid;
         rsp       <= rsp_nxt;    // zero when idle
      end
   end

endmodule

`default_nettype wire

// File: src/plru_tree.sv
`timescale 1ns/10ps
`default_nettype none

module plru_tree (
   input  wire                      clk,
   input  wire                      rst,
   input  wire cdir_pkg::dir_req_t  req,
   input  wire cdir_pkg::plru_upd_t plru_upd,
   output logic [cdir_pkg::WAY_W-1:0] victim_way
);

   import cdir_pkg::*;

   // heap numbered tree nodes
   //
   //                [1]              0 goes left, 1 goes right
   //          [2]         [3]
   //       (w0) (w1)   (w2) (w3)     leaf id minus N_WAYS is the way
   //
   // node 0 does not exist, so each set keeps bits N_WAYS-1 down to 1

   logic [N_SETS-1:0][N_WAYS-1:1] tree_q;     // tree bits of every set
   logic [N_WAYS-1:1]             tree_rd;    // tree of the requested set
   logic [N_WAYS-1:1]             tree_nxt;   // tree after the update

   logic [WAY_W:0]                node_id [WAY_W+1];  // node visited per level
   logic [WAY_W:0]                upd_leaf;           // leaf id of accessed way

   assign tree_rd = tree_q[req.set];

   // walk from the root down, one level per step
   assign node_id[0] = (WAY_W+1)'(1);
   for (genvar lvl = 1; lvl <= WAY_W; lvl++) begin : g_walk
      // child id is parent id shifted left with the node bit as lsb
      assign node_id[lvl] = {node_id[lvl-1][WAY_W-1:0], tree_rd[node_id[lvl-1]]};
   end

   // leaf id minus N_WAYS is just the low bits
   assign victim_way = node_id[WAY_W][WAY_W-1:0];

   // leaf of the accessed way, top bit set means offset by N_WAYS
   assign upd_leaf = {1'b1, plru_upd.way};

   // rewrite the nodes on the path so they point away from the accessed way
   for (genvar lvl = 1; lvl <= WAY_W; lvl++) begin : g_level
      for (genvar j = 0; j < (1 << (lvl-1)); j++) begin : g_node
         // ancestor of the leaf at this level equals this node when on path
         // bit WAY_W-lvl of the way tells which child the path takes
         assign tree_nxt[(1 << (lvl-1)) + j] =
            ((upd_leaf >> (WAY_W+1-lvl)) == ((1 << (lvl-1)) + j)) ?
               ~upd_leaf[WAY_W-lvl] :                  // left child taken -> point right
               tree_rd[(1 << (lvl-1)) + j];            // off path, keep
      end
   end

   // tree registers, all point left after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         tree_q <= '0;
      end else if (plru_upd.en) begin
         tree_q[req.set] <= tree_nxt;
      end
   end

endmodule

`default_nettype wire

// File: src/tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module tag_store (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    req_valid,
   input  wire cdir_pkg::dir_req_t req,
   input  wire cdir_pkg::tag_wr_t tag_wr,
   output logic [cdir_pkg::N_WAYS-1:0]                      way_hit,
   output logic [cdir_pkg::N_WAYS-1:0]                      way_valid,
   output logic [cdir_pkg::N_WAYS-1:0][cdir_pkg::TAG_W-1:0] way_tags
);

   import cdir_pkg::*;

   // valid bits live in one flat register so reset clears them at once
   logic [N_SETS-1:0][N_WAYS-1:0] valid_q;

   // tag array, one row per set
   logic [N_WAYS-1:0][TAG_W-1:0]  tag_q [N_SETS];

   logic                          wr_en;

   assign wr_en = req_valid & tag_wr.en;   // only a live request writes

   // asynchronous read of the addressed set
   assign way_valid = valid_q[req.set];
   assign way_tags  = tag_q[req.set];

   // compare every way against the request tag
   for (genvar w = 0; w < N_WAYS; w++) begin : g_cmp
      assign way_hit[w] = way_valid[w] & (way_tags[w] == req.tag);
   end

   // valid bits, cleared on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (wr_en) begin
         valid_q[req.set][tag_wr.way] <= tag_wr.valid;   // set on fill, clear on inval
      end
   end

   // tags only matter when valid, no reset here
   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_q[req.set][tag_wr.way] <= req.tag;  // request tag always goes in
      end
   end

endmodule

`default_nettype wire
